/* common/ioMap_consts.svh */
`ifndef IOMAP_CONSTS_SVH
`define IOMAP_CONSTS_SVH

// Peripheral base addresses, registers are one word apart
`define IO_ADDR_HEX   32'hFFFFF000
`define IO_ADDR_LEDR  32'hFFFFF020
`define IO_ADDR_KEY   32'hFFFFF080
`define IO_ADDR_SW    32'hFFFFF090
`define IO_ADDR_TIMER 32'hFFFFF100

// Register offsets inside a window
`define REG_DATA 2'd0
`define REG_CTRL 2'd1
`define REG_TLIM 2'd1
`define REG_TCTL 2'd2

// Control/status bit positions
`define STAT_READY   0
`define STAT_OVERRUN 1
`define STAT_IRQ_EN  4

// Sample periods and timer tick, in clock cycles
`define KEY_SAMPLE_CYCLES 16
`define SW_SAMPLE_CYCLES  64
`define TIMER_TICK_CYCLES 50

// Hex display contents out of reset
`define HEX_RESET_VALUE 24'hFEDEAD

`endif

/* common/ioPkg.sv */
package ioPkg;

  // Wishbone side
  typedef logic [31:0] busAddr_t;
  typedef logic [31:0] busData_t;

  // Register index inside a peripheral window, taken from address bits 3:2
  typedef logic [1:0] regOffset_t;

  // Display payloads
  typedef logic [9:0]  ledData_t;
  typedef logic [23:0] hexDigits_t;

  // One digit, active low, segment g in bit 6
  typedef logic [6:0] segments_t;

  // Debounced board inputs
  typedef logic [3:0] keyData_t;
  typedef logic [9:0] swData_t;

  // Decoder targets
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_LEDR,
    SEL_HEX,
    SEL_KEY,
    SEL_SW,
    SEL_TIMER
  } periphSel_t;

endpackage

/* verilog/wbDecoder.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module wbDecoder (
  input  logic               clk,
  input  logic               RESET,
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  ioPkg::busAddr_t    adr,
  input  ioPkg::busData_t    datW,
  output ioPkg::busData_t    datR,
  output logic               ack,
  output ioPkg::busData_t    wrData,
  output ioPkg::regOffset_t  regOffset,
  output logic               ledrWrEn,
  output logic               hexWrEn,
  output logic               keyRdEn,
  output logic               keyWrEn,
  output logic               swRdEn,
  output logic               swWrEn,
  output logic               timerRdEn,
  output logic               timerWrEn,
  input  ioPkg::busData_t    ledrRd,
  input  ioPkg::busData_t    hexRd,
  input  ioPkg::busData_t    keyRd,
  input  ioPkg::busData_t    swRd,
  input  ioPkg::busData_t    timerRd
);

  import ioPkg::*;

  periphSel_t sel;
  busData_t   readWord;
  logic       xfer;

  // The cycle before ack rises, peripherals act on the ack edge
  assign xfer = cyc && stb && !ack;

  assign wrData    = datW;
  assign regOffset = adr[3:2];

  // Windows are 16 bytes, offsets outside a block's registers stay unmapped
  always_comb begin
    sel = SEL_NONE;
    if (adr[1:0] == 2'b00) begin
      case ({adr[31:4], 4'h0})
        `IO_ADDR_HEX:   sel = (regOffset == `REG_DATA) ? SEL_HEX : SEL_NONE;
        `IO_ADDR_LEDR:  sel = (regOffset == `REG_DATA) ? SEL_LEDR : SEL_NONE;
        `IO_ADDR_KEY:   sel = (regOffset <= `REG_CTRL) ? SEL_KEY : SEL_NONE;
        `IO_ADDR_SW:    sel = (regOffset <= `REG_CTRL) ? SEL_SW : SEL_NONE;
        `IO_ADDR_TIMER: sel = (regOffset <= `REG_TCTL) ? SEL_TIMER : SEL_NONE;
        default:        sel = SEL_NONE;
      endcase
    end
  end

  assign ledrWrEn  = xfer && we && (sel == SEL_LEDR);
  assign hexWrEn   = xfer && we && (sel == SEL_HEX);
  assign keyWrEn   = xfer && we && (sel == SEL_KEY);
  assign keyRdEn   = xfer && !we && (sel == SEL_KEY);
  assign swWrEn    = xfer && we && (sel == SEL_SW);
  assign swRdEn    = xfer && !we && (sel == SEL_SW);
  assign timerWrEn = xfer && we && (sel == SEL_TIMER);
  assign timerRdEn = xfer && !we && (sel == SEL_TIMER);

  always_comb begin
    case (sel)
      SEL_LEDR:  readWord = ledrRd;
      SEL_HEX:   readWord = hexRd;
      SEL_KEY:   readWord = keyRd;
      SEL_SW:    readWord = swRd;
      SEL_TIMER: readWord = timerRd;
      default:   readWord = '0;
    endcase
  end

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ack <= 1'b0;
    end else begin
      ack <= xfer;
    end
  end

  // Read data held for the single ack cycle
  always_ff @(posedge clk) begin
    if (xfer) begin
      datR <= we ? '0 : readWord;
    end
  end

endmodule

/* peripherals/displayRegs.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module displayRegs (
  input  logic              clk,
  input  logic              RESET,
  input  logic              ledrWrEn,
  input  logic              hexWrEn,
  input  ioPkg::busData_t   wrData,
  output ioPkg::busData_t   ledrRd,
  output ioPkg::busData_t   hexRd,
  output ioPkg::ledData_t   ledr,
  output ioPkg::segments_t  hex0,
  output ioPkg::segments_t  hex1,
  output ioPkg::segments_t  hex2,
  output ioPkg::segments_t  hex3,
  output ioPkg::segments_t  hex4,
  output ioPkg::segments_t  hex5
);

  import ioPkg::*;

  // Glyphs 0 to F, active low
  localparam segments_t SegTable [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  ledData_t   ledReg;
  hexDigits_t hexReg;

  function automatic segments_t toSegments(input logic [3:0] nibble);
    return SegTable[nibble];
  endfunction

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ledReg <= '0;
      hexReg <= `HEX_RESET_VALUE;
    end else begin
      if (ledrWrEn) begin
        ledReg <= wrData[$bits(ledData_t)-1:0];
      end
      if (hexWrEn) begin
        hexReg <= wrData[$bits(hexDigits_t)-1:0];
      end
    end
  end

  assign ledr   = ledReg;
  assign ledrRd = {{($bits(busData_t) - $bits(ledData_t)){1'b0}}, ledReg};
  assign hexRd  = {{($bits(busData_t) - $bits(hexDigits_t)){1'b0}}, hexReg};

  // Digit 0 is the rightmost, lowest nibble
  assign hex0 = toSegments(hexReg[3:0]);
  assign hex1 = toSegments(hexReg[7:4]);
  assign hex2 = toSegments(hexReg[11:8]);
  assign hex3 = toSegments(hexReg[15:12]);
  assign hex4 = toSegments(hexReg[19:16]);
  assign hex5 = toSegments(hexReg[23:20]);

endmodule

/* peripherals/debouncedInput.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module debouncedInput #(
  parameter type payload_t    = ioPkg::keyData_t,
  parameter int  sampleCycles = 16
) (
  input  logic              clk,
  input  logic              RESET,
  input  payload_t          pins,
  input  logic              rdEn,
  input  logic              wrEn,
  input  ioPkg::regOffset_t regOffset,
  input  ioPkg::busData_t   wrData,
  output ioPkg::busData_t   rdData,
  output logic              irq
);

  import ioPkg::*;

  localparam int CountW = $clog2(sampleCycles);

  logic [CountW-1:0] periodCount;
  logic              sampleTick;
  payload_t          sampleNew;
  payload_t          sampleOld;
  payload_t          dataReg;
  logic              ready;
  logic              overrun;
  logic              irqEn;
  logic              dataRead;
  logic              ctrlWrite;
  logic              takeSample;
  busData_t          ctrlWord;

  assign sampleTick = (periodCount == CountW'(sampleCycles - 1));
  assign dataRead   = rdEn && (regOffset == `REG_DATA);
  assign ctrlWrite  = wrEn && (regOffset == `REG_CTRL);

  // Two agreeing samples that differ from the stored value
  assign takeSample = sampleTick && (sampleOld == sampleNew) && (dataReg != sampleNew);

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      periodCount <= '0;
      sampleNew   <= '0;
      sampleOld   <= '0;
      dataReg     <= '0;
      ready       <= 1'b0;
      overrun     <= 1'b0;
      irqEn       <= 1'b0;
    end else begin
      periodCount <= sampleTick ? '0 : periodCount + 1'b1;
      if (sampleTick) begin
        sampleNew <= pins;
        sampleOld <= sampleNew;
      end
      if (dataRead) begin
        ready <= 1'b0;
      end
      // A read on the same edge took the old value, so no overrun then
      if (takeSample) begin
        dataReg <= sampleNew;
        if (ready && !dataRead) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end
      if (ctrlWrite) begin
        if (!wrData[`STAT_OVERRUN]) begin
          overrun <= 1'b0;
        end
        irqEn <= wrData[`STAT_IRQ_EN];
      end
    end
  end

  always_comb begin
    ctrlWord                = '0;
    ctrlWord[`STAT_READY]   = ready;
    ctrlWord[`STAT_OVERRUN] = overrun;
    ctrlWord[`STAT_IRQ_EN]  = irqEn;
  end

  always_comb begin
    rdData = '0;
    if (rdEn) begin
      if (regOffset == `REG_DATA) begin
        rdData[$bits(payload_t)-1:0] = dataReg;
      end else if (regOffset == `REG_CTRL) begin
        rdData = ctrlWord;
      end
    end
  end

  assign irq = ready && irqEn;

endmodule

/* peripherals/intervalTimer.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module intervalTimer #(
  parameter int tickCycles = 50
) (
  input  logic              clk,
  input  logic              RESET,
  input  logic              rdEn,
  input  logic              wrEn,
  input  ioPkg::regOffset_t regOffset,
  input  ioPkg::busData_t   wrData,
  output ioPkg::busData_t   rdData,
  output logic              irq
);

  import ioPkg::*;

  localparam int PreW = $clog2(tickCycles);

  logic [PreW-1:0] preCount;
  logic            tick;
  busData_t        count;
  busData_t        limit;
  logic            ready;
  logic            overrun;
  logic            irqEn;
  logic            limitHit;
  busData_t        ctrlWord;

  assign tick = (preCount == PreW'(tickCycles - 1));

  // A zero limit leaves the timer free running
  assign limitHit = (limit != '0) && (count >= limit);

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      preCount <= '0;
      count    <= '0;
      limit    <= '0;
      ready    <= 1'b0;
      overrun  <= 1'b0;
      irqEn    <= 1'b0;
    end else begin
      preCount <= tick ? '0 : preCount + 1'b1;

      // Bus writes win over the limit wrap, which wins over the tick
      if (wrEn && (regOffset == `REG_TLIM)) begin
        limit <= wrData;
        count <= '0;
      end else if (wrEn && (regOffset == `REG_DATA)) begin
        count <= wrData;
      end else if (limitHit) begin
        count <= '0;
      end else if (tick) begin
        count <= count + 1'b1;
      end

      if (limitHit) begin
        if (ready) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end

      // Written zeros clear the status bits
      if (wrEn && (regOffset == `REG_TCTL)) begin
        if (!wrData[`STAT_READY]) begin
          ready <= 1'b0;
        end
        if (!wrData[`STAT_OVERRUN]) begin
          overrun <= 1'b0;
        end
        irqEn <= wrData[`STAT_IRQ_EN];
      end
    end
  end

  always_comb begin
    ctrlWord                = '0;
    ctrlWord[`STAT_READY]   = ready;
    ctrlWord[`STAT_OVERRUN] = overrun;
    ctrlWord[`STAT_IRQ_EN]  = irqEn;
  end

  always_comb begin
    rdData = '0;
    if (rdEn) begin
      case (regOffset)
        `REG_DATA: rdData = count;
        `REG_TLIM: rdData = limit;
        `REG_TCTL: rdData = ctrlWord;
        default:   rdData = '0;
      endcase
    end
  end

  assign irq = ready && irqEn;

endmodule

/* verilog/ioSubsystem.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module ioSubsystem (
  input  logic             clk,
  input  logic             RESET,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  ioPkg::busAddr_t  adr,
  input  ioPkg::busData_t  datW,
  output ioPkg::busData_t  datR,
  output logic             ack,
  input  ioPkg::keyData_t  key,
  input  ioPkg::swData_t   sw,
  output ioPkg::ledData_t  ledr,
  output ioPkg::segments_t hex0,
  output ioPkg::segments_t hex1,
  output ioPkg::segments_t hex2,
  output ioPkg::segments_t hex3,
  output ioPkg::segments_t hex4,
  output ioPkg::segments_t hex5,
  output logic             keyIrq,
  output logic             swIrq,
  output logic             timerIrq
);

  import ioPkg::*;

  busData_t   wrData;
  regOffset_t regOffset;
  logic       ledrWrEn;
  logic       hexWrEn;
  logic       keyRdEn;
  logic       keyWrEn;
  logic       swRdEn;
  logic       swWrEn;
  logic       timerRdEn;
  logic       timerWrEn;
  busData_t   ledrRd;
  busData_t   hexRd;
  busData_t   keyRd;
  busData_t   swRd;
  busData_t   timerRd;

  wbDecoder wbDecoder_i (
    .clk       (clk),
    .RESET     (RESET),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .datW      (datW),
    .datR      (datR),
    .ack       (ack),
    .wrData    (wrData),
    .regOffset (regOffset),
    .ledrWrEn  (ledrWrEn),
    .hexWrEn   (hexWrEn),
    .keyRdEn   (keyRdEn),
    .keyWrEn   (keyWrEn),
    .swRdEn    (swRdEn),
    .swWrEn    (swWrEn),
    .timerRdEn (timerRdEn),
    .timerWrEn (timerWrEn),
    .ledrRd    (ledrRd),
    .hexRd     (hexRd),
    .keyRd     (keyRd),
    .swRd      (swRd),
    .timerRd   (timerRd)
  );

  displayRegs displayRegs_i (
    .clk      (clk),
    .RESET    (RESET),
    .ledrWrEn (ledrWrEn),
    .hexWrEn  (hexWrEn),
    .wrData   (wrData),
    .ledrRd   (ledrRd),
    .hexRd    (hexRd),
    .ledr     (ledr),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5)
  );

  // Keys are active low on the board, stored as pressed = 1
  debouncedInput #(
    .payload_t    (keyData_t),
    .sampleCycles (`KEY_SAMPLE_CYCLES)
  ) keyPort (
    .clk       (clk),
    .RESET     (RESET),
    .pins      (~key),
    .rdEn      (keyRdEn),
    .wrEn      (keyWrEn),
    .regOffset (regOffset),
    .wrData    (wrData),
    .rdData    (keyRd),
    .irq       (keyIrq)
  );

  debouncedInput #(
    .payload_t    (swData_t),
    .sampleCycles (`SW_SAMPLE_CYCLES)
  ) swPort (
    .clk       (clk),
    .RESET     (RESET),
    .pins      (sw),
    .rdEn      (swRdEn),
    .wrEn      (swWrEn),
    .regOffset (regOffset),
    .wrData    (wrData),
    .rdData    (swRd),
    .irq       (swIrq)
  );

  intervalTimer #(
    .tickCycles (`TIMER_TICK_CYCLES)
  ) intervalTimer_i (
    .clk       (clk),
    .RESET     (RESET),
    .rdEn      (timerRdEn),
    .wrEn      (timerWrEn),
    .regOffset (regOffset),
    .wrData    (wrData),
    .rdData    (timerRd),
    .irq       (timerIrq)
  );

endmodule

/* verif/ioChecker.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module ioChecker (
  input logic              clk,
  input logic              RESET,
  input logic              cyc,
  input logic              stb,
  input logic              we,
  input ioPkg::busAddr_t   adr,
  input ioPkg::busData_t   datW,
  input ioPkg::busData_t   datR,
  input logic              ack,
  input ioPkg::keyData_t   key,
  input ioPkg::swData_t    sw,
  input ioPkg::ledData_t   ledr,
  input ioPkg::segments_t  hex0,
  input ioPkg::segments_t  hex1,
  input ioPkg::segments_t  hex2,
  input ioPkg::segments_t  hex3,
  input ioPkg::segments_t  hex4,
  input ioPkg::segments_t  hex5,
  input logic              keyIrq,
  input logic              swIrq,
  input logic              timerIrq
);

  import ioPkg::*;

  // Standard active-low glyphs 0 to F with segment g in bit 6
  localparam segments_t Glyphs [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };
  localparam int Periods [2] = '{`KEY_SAMPLE_CYCLES, `SW_SAMPLE_CYCLES};

  int valueErrors = 0;
  int protocolErrors = 0;

  // Model state per port with the key port at index 0
  ledData_t   mLed;
  hexDigits_t mHex;
  logic [9:0] pNew [2];
  logic [9:0] pOld [2];
  logic [9:0] pData [2];
  logic       pReady [2];
  logic       pOver [2];
  logic       pEn [2];
  int         pCount [2];
  int         tPre;
  busData_t   tCount;
  busData_t   tLim;
  logic       tReady;
  logic       tOver;
  logic       tEn;

  logic     pending;
  logic     pendRead;
  busData_t pendData;
  segments_t segs [6];

  assign segs[0] = hex0;
  assign segs[1] = hex1;
  assign segs[2] = hex2;
  assign segs[3] = hex3;
  assign segs[4] = hex4;
  assign segs[5] = hex5;

  task automatic valueError(input string what, input busData_t got, input busData_t exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    valueErrors++;
  endtask

  function automatic busData_t statusWord(input logic rdy, input logic ovr, input logic en);
    busData_t w;
    w = '0;
    w[`STAT_READY] = rdy;
    w[`STAT_OVERRUN] = ovr;
    w[`STAT_IRQ_EN] = en;
    return w;
  endfunction

  function automatic busData_t modelRead(input busAddr_t a);
    busData_t r;
    r = '0;
    case (a)
      `IO_ADDR_LEDR:       r = 32'(mLed);
      `IO_ADDR_HEX:        r = 32'(mHex);
      `IO_ADDR_KEY:        r = 32'(pData[0]);
      `IO_ADDR_KEY + 4:    r = statusWord(pReady[0], pOver[0], pEn[0]);
      `IO_ADDR_SW:         r = 32'(pData[1]);
      `IO_ADDR_SW + 4:     r = statusWord(pReady[1], pOver[1], pEn[1]);
      `IO_ADDR_TIMER:      r = tCount;
      `IO_ADDR_TIMER + 4:  r = tLim;
      `IO_ADDR_TIMER + 8:  r = statusWord(tReady, tOver, tEn);
      default:             r = '0;
    endcase
    return r;
  endfunction

  task automatic resetModel();
    mLed = '0;
    mHex = `HEX_RESET_VALUE;
    for (int p = 0; p < 2; p++) begin
      pNew[p] = '0;
      pOld[p] = '0;
      pData[p] = '0;
      pReady[p] = 1'b0;
      pOver[p] = 1'b0;
      pEn[p] = 1'b0;
      pCount[p] = 0;
    end
    tPre = 0;
    tCount = '0;
    tLim = '0;
    tReady = 1'b0;
    tOver = 1'b0;
    tEn = 1'b0;
    pending = 1'b0;
  endtask

  // One clock of a debounced port
  task automatic stepPort(input int p, input logic [9:0] pins, input logic rd,
                          input logic ctlWr, input busData_t d);
    logic tick;
    logic take;
    logic wasReady;
    tick = (pCount[p] == Periods[p] - 1);
    take = tick && (pOld[p] == pNew[p]) && (pData[p] != pNew[p]);
    wasReady = pReady[p];
    pCount[p] = tick ? 0 : pCount[p] + 1;
    if (rd) begin
      pReady[p] = 1'b0;
    end
    if (take) begin
      pData[p] = pNew[p];
      if (wasReady && !rd) begin
        pOver[p] = 1'b1;
      end else begin
        pReady[p] = 1'b1;
      end
    end
    if (ctlWr) begin
      if (!d[`STAT_OVERRUN]) begin
        pOver[p] = 1'b0;
      end
      pEn[p] = d[`STAT_IRQ_EN];
    end
    if (tick) begin
      pOld[p] = pNew[p];
      pNew[p] = pins;
    end
  endtask

  task automatic stepTimer(input logic wr, input regOffset_t off, input busData_t d);
    logic tick;
    logic hit;
    tick = (tPre == `TIMER_TICK_CYCLES - 1);
    hit = (tLim != 0) && (tCount >= tLim);
    tPre = tick ? 0 : tPre + 1;
    if (wr && off == `REG_TLIM) begin
      tLim = d;
      tCount = '0;
    end else if (wr && off == `REG_DATA) begin
      tCount = d;
    end else if (hit) begin
      tCount = '0;
    end else if (tick) begin
      tCount = tCount + 1;
    end
    if (hit) begin
      if (tReady) begin
        tOver = 1'b1;
      end else begin
        tReady = 1'b1;
      end
    end
    if (wr && off == `REG_TCTL) begin
      if (!d[`STAT_READY]) begin
        tReady = 1'b0;
      end
      if (!d[`STAT_OVERRUN]) begin
        tOver = 1'b0;
      end
      tEn = d[`STAT_IRQ_EN];
    end
  endtask

  task automatic checkOutputs();
    if (ledr !== mLed) valueError("ledr", 32'(ledr), 32'(mLed));
    for (int i = 0; i < 6; i++) begin
      if (segs[i] !== Glyphs[mHex[4*i +: 4]]) begin
        valueError($sformatf("hex%0d", i), 32'(segs[i]), 32'(Glyphs[mHex[4*i +: 4]]));
      end
    end
    if (keyIrq !== (pReady[0] && pEn[0])) begin
      valueError("keyIrq", 32'(keyIrq), 32'(pReady[0] && pEn[0]));
    end
    if (swIrq !== (pReady[1] && pEn[1])) begin
      valueError("swIrq", 32'(swIrq), 32'(pReady[1] && pEn[1]));
    end
    if (timerIrq !== (tReady && tEn)) begin
      valueError("timerIrq", 32'(timerIrq), 32'(tReady && tEn));
    end
  endtask

  // Values seen here are the ones settled before the edge
  always @(posedge clk or posedge RESET) begin
    logic     xfer;
    logic     isWr;
    logic     isRd;
    logic     tWr;
    if (RESET) begin
      resetModel();
    end else begin
      checkOutputs();
      if (pending) begin
        if (ack !== 1'b1) begin
          $display("Handshake failure at %0t: no ack one cycle after strobe", $time);
          protocolErrors++;
        end else if (pendRead && datR !== pendData) begin
          valueError("datR", datR, pendData);
        end
        pending = 1'b0;
      end else if (ack === 1'b1) begin
        $display("Handshake failure at %0t: ack high for more than one cycle", $time);
        protocolErrors++;
      end
      xfer = cyc && stb && !ack;
      isWr = xfer && we;
      isRd = xfer && !we;
      if (xfer) begin
        pending = 1'b1;
        pendRead = !we;
        pendData = modelRead(adr);
      end
      tWr = isWr && (adr == `IO_ADDR_TIMER || adr == `IO_ADDR_TIMER + 4 ||
                     adr == `IO_ADDR_TIMER + 8);
      stepPort(0, {6'b0, ~key}, isRd && adr == `IO_ADDR_KEY,
               isWr && adr == `IO_ADDR_KEY + 4, datW);
      stepPort(1, sw, isRd && adr == `IO_ADDR_SW,
               isWr && adr == `IO_ADDR_SW + 4, datW);
      stepTimer(tWr, adr[3:2], datW);
      if (isWr && adr == `IO_ADDR_LEDR) mLed = datW[9:0];
      if (isWr && adr == `IO_ADDR_HEX) mHex = datW[23:0];
    end
  end

endmodule

/* verif/tbIoSubsystem.sv */
`timescale 1ns/10ps
`include "ioMap_consts.svh"

module tbIoSubsystem;

  import ioPkg::*;

  localparam int MaxGap = 6;
  localparam int MaxStbDelay = 3;
  localparam int RandomXfers = 250;
  localparam int InputReads = 60;
  localparam int TotalXfers = RandomXfers + 2 * InputReads + 20;
  localparam int XferBudget = MaxGap + MaxStbDelay + 4 + 3 * `SW_SAMPLE_CYCLES;
  localparam int WatchdogCycles = TotalXfers * XferBudget + 20000;

  logic      clk = 1'b0;
  logic      RESET;
  logic      cyc;
  logic      stb;
  logic      we;
  busAddr_t  adr;
  busData_t  datW;
  busData_t  datR;
  logic      ack;
  keyData_t  key;
  swData_t   sw;
  ledData_t  ledr;
  segments_t hex0;
  segments_t hex1;
  segments_t hex2;
  segments_t hex3;
  segments_t hex4;
  segments_t hex5;
  logic      keyIrq;
  logic      swIrq;
  logic      timerIrq;

  int   ackTimeouts = 0;
  logic pinsDone = 1'b0;

  busAddr_t addrs [10] = '{
    `IO_ADDR_LEDR, `IO_ADDR_HEX, `IO_ADDR_KEY, `IO_ADDR_KEY + 4, `IO_ADDR_SW,
    `IO_ADDR_SW + 4, `IO_ADDR_TIMER, `IO_ADDR_TIMER + 4, `IO_ADDR_TIMER + 8, 32'hFFFFF040
  };

  always #10 clk = ~clk;

  ioSubsystem ioSubsystem_i (.*);
  ioChecker checker_i (.*);

  // Starts and ends on a falling edge
  task automatic busTransfer(input logic write, input busAddr_t a, input busData_t d);
    int gap;
    int lead;
    int waited;
    gap = $urandom % (MaxGap + 1);
    lead = $urandom % (MaxStbDelay + 1);
    waited = 0;
    repeat (gap) @(negedge clk);
    cyc = 1'b1;
    we = write;
    adr = a;
    datW = d;
    repeat (lead) @(negedge clk);
    stb = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < 4);
    if (!ack) begin
      $display("Bus transfer to %h at %0t never got an ack", a, $time);
      ackTimeouts++;
    end
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic drivePins();
    logic [31:0] r;
    int hold;
    while (!pinsDone) begin
      r = $urandom;
      key = r[3:0];
      sw = r[13:4];
      hold = 3 * `SW_SAMPLE_CYCLES + $urandom % 128;
      repeat (hold) @(negedge clk);
    end
  endtask

  initial begin
    int idx;
    logic wr;
    busAddr_t a;
    int lim;
    void'($urandom(32'hf995_0d10));
    RESET = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datW = '0;
    key = '1;
    sw = '0;
    repeat (5) @(negedge clk);
    RESET = 1'b0;

    // Reset values
    busTransfer(1'b0, `IO_ADDR_LEDR, '0);
    busTransfer(1'b0, `IO_ADDR_HEX, '0);

    fork
      drivePins();
    join_none

    // Random traffic on display, status and unmapped addresses
    repeat (RandomXfers) begin
      idx = $urandom % 11;
      a = (idx == 10) ? busAddr_t'($urandom) : addrs[idx];
      wr = $urandom % 2;
      if (idx inside {2, 4, 6, 7, 8}) wr = 1'b0;
      busTransfer(wr, a, $urandom);
    end

    // Debounced inputs with interrupts enabled
    busTransfer(1'b1, `IO_ADDR_KEY + 4, 32'h10);
    busTransfer(1'b1, `IO_ADDR_SW + 4, 32'h10);
    repeat (InputReads) begin
      repeat ($urandom % (3 * `SW_SAMPLE_CYCLES)) @(negedge clk);
      idx = 2 + $urandom % 4;
      busTransfer(1'b0, addrs[idx], '0);
      if ($urandom % 8 == 0) begin
        busTransfer(1'b1, addrs[idx] | 32'h4, {27'b0, 1'b1, 4'b0});
      end
    end

    // Timer limit and interrupt
    lim = 1 + $urandom % 5;
    busTransfer(1'b1, `IO_ADDR_TIMER + 8, 32'h10);
    busTransfer(1'b1, `IO_ADDR_TIMER + 4, lim);
    repeat ((lim + 2) * `TIMER_TICK_CYCLES) @(negedge clk);
    busTransfer(1'b0, `IO_ADDR_TIMER + 8, '0);
    busTransfer(1'b1, `IO_ADDR_TIMER + 8, 32'h10);
    repeat (3) @(negedge clk);
    busTransfer(1'b0, `IO_ADDR_TIMER, '0);

    pinsDone = 1'b1;
    repeat (4) @(negedge clk);
    $display("Errors: value %0d, protocol %0d, ack timeout %0d",
             checker_i.valueErrors, checker_i.protocolErrors, ackTimeouts);
    if (checker_i.valueErrors == 0 && checker_i.protocolErrors == 0 && ackTimeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * 20);
    $display("Watchdog expired at %0t, the test did not finish in time", $time);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/ioPkg.sv
verilog/wbDecoder.sv
peripherals/displayRegs.sv
peripherals/debouncedInput.sv
peripherals/intervalTimer.sv
verilog/ioSubsystem.sv
verif/ioChecker.sv
verif/tbIoSubsystem.sv

/* Bender.yml */
package:
  name: ioSubsystem

sources:
  - include_dirs:
      - common
    files:
      - common/ioPkg.sv
      - verilog/wbDecoder.sv
      - peripherals/displayRegs.sv
      - peripherals/debouncedInput.sv
      - peripherals/intervalTimer.sv
      - verilog/ioSubsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/ioChecker.sv
      - verif/tbIoSubsystem.sv
